// File: matmul_pkg.sv
package matmul_pkg;

  ////////////////////
  // Default sizes for the top level
  ////////////////////

  // Matrix dimension of the single tile
  localparam int DEF_N = 4;

  // Signed element width of A, B and C
  localparam int DEF_DWIDTH = 8;

  localparam int DEF_AWIDTH = 10;
  localparam int DEF_STRIDE_WIDTH = 8;

  ////////////////////
  // Fixed pipeline constants
  ////////////////////

  // Cycles from a read strobe to the data on the memory return bus
  localparam int MEM_LATENCY = 1;

  // Operand flop, product flop and accumulator register
  localparam int MAC_STAGES = 3;

  // States of one multiply run
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_FETCH,
    ST_WAIT,
    ST_DRAIN,
    ST_DONE
  } seq_state_e;

endpackage

// File: matmul_top.sv
`timescale 1ns/100ps

module matmul_top #(
  parameter int N = matmul_pkg::DEF_N,
  parameter int DWIDTH = matmul_pkg::DEF_DWIDTH,
  parameter int AWIDTH = matmul_pkg::DEF_AWIDTH,
  parameter int STRIDE_WIDTH = matmul_pkg::DEF_STRIDE_WIDTH
) (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    i_start,
  output logic                    o_done,
  input  logic [AWIDTH-1:0]       i_base_a,
  input  logic [AWIDTH-1:0]       i_base_b,
  input  logic [AWIDTH-1:0]       i_base_c,
  input  logic [STRIDE_WIDTH-1:0] i_stride_a,
  input  logic [STRIDE_WIDTH-1:0] i_stride_b,
  input  logic [STRIDE_WIDTH-1:0] i_stride_c,
  output logic [AWIDTH-1:0]       o_a_addr,
  output logic                    o_a_rd,
  input  logic [N*DWIDTH-1:0]     i_a_data,
  output logic [AWIDTH-1:0]       o_b_addr,
  output logic                    o_b_rd,
  input  logic [N*DWIDTH-1:0]     i_b_data,
  output logic [AWIDTH-1:0]       o_c_addr,
  output logic [N*DWIDTH-1:0]     o_c_data,
  output logic                    o_c_valid
);

  logic clear;
  logic fetch_go;
  logic drain_go;
  logic drain_last;
  logic [N*DWIDTH-1:0] a_lane;
  logic [N*DWIDTH-1:0] b_lane;
  logic [N*N*DWIDTH-1:0] acc;

  run_sequencer #(
    .N(N)
  ) i_run_sequencer (
    .clk          (clk),
    .reset        (reset),
    .i_start      (i_start),
    .i_drain_last (drain_last),
    .o_clear      (clear),
    .o_fetch_go   (fetch_go),
    .o_drain_go   (drain_go),
    .o_done       (o_done)
  );

  operand_fetch #(
    .N(N),
    .DWIDTH(DWIDTH),
    .AWIDTH(AWIDTH),
    .STRIDE_WIDTH(STRIDE_WIDTH)
  ) i_operand_fetch (
    .clk        (clk),
    .i_clear    (clear),
    .i_fetch_go (fetch_go),
    .i_base_a   (i_base_a),
    .i_base_b   (i_base_b),
    .i_stride_a (i_stride_a),
    .i_stride_b (i_stride_b),
    .i_a_data   (i_a_data),
    .i_b_data   (i_b_data),
    .o_a_addr   (o_a_addr),
    .o_b_addr   (o_b_addr),
    .o_a_rd     (o_a_rd),
    .o_b_rd     (o_b_rd),
    .o_a_lane   (a_lane),
    .o_b_lane   (b_lane)
  );

  systolic_array #(
    .N(N),
    .DWIDTH(DWIDTH)
  ) i_systolic_array (
    .clk      (clk),
    .i_clear  (clear),
    .i_a_lane (a_lane),
    .i_b_lane (b_lane),
    .o_acc    (acc)
  );

  result_drain #(
    .N(N),
    .DWIDTH(DWIDTH),
    .AWIDTH(AWIDTH),
    .STRIDE_WIDTH(STRIDE_WIDTH)
  ) i_result_drain (
    .clk          (clk),
    .i_clear      (clear),
    .i_drain_go   (drain_go),
    .i_base_c     (i_base_c),
    .i_stride_c   (i_stride_c),
    .i_acc        (acc),
    .o_c_addr     (o_c_addr),
    .o_c_data     (o_c_data),
    .o_c_valid    (o_c_valid),
    .o_drain_last (drain_last)
  );

endmodule

// File: operand_fetch.sv
`timescale 1ns/100ps

module operand_fetch #(
  parameter int N = 4,
  parameter int DWIDTH = 8,
  parameter int AWIDTH = 10,
  parameter int STRIDE_WIDTH = 8
) (
  input  logic                    clk,
  input  logic                    i_clear,
  input  logic                    i_fetch_go,
  input  logic [AWIDTH-1:0]       i_base_a,
  input  logic [AWIDTH-1:0]       i_base_b,
  input  logic [STRIDE_WIDTH-1:0] i_stride_a,
  input  logic [STRIDE_WIDTH-1:0] i_stride_b,
  input  logic [N*DWIDTH-1:0]     i_a_data,
  input  logic [N*DWIDTH-1:0]     i_b_data,
  output logic [AWIDTH-1:0]       o_a_addr,
  output logic [AWIDTH-1:0]       o_b_addr,
  output logic                    o_a_rd,
  output logic                    o_b_rd,
  output logic [N*DWIDTH-1:0]     o_a_lane,
  output logic [N*DWIDTH-1:0]     o_b_lane
);

  localparam int LAT_END = matmul_pkg::MEM_LATENCY + N;
  localparam int LAT_W = $clog2(LAT_END + 1);
  localparam int LEFT_W = $clog2(N);

  // Side 0 reads the columns of A and side 1 the rows of B
  for (genvar s = 0; s < 2; s++) begin : g_side
    wire [AWIDTH-1:0] base = (s == 0) ? i_base_a : i_base_b;
    wire [STRIDE_WIDTH-1:0] stride = (s == 0) ? i_stride_a : i_stride_b;
    wire [N*DWIDTH-1:0] rdata = (s == 0) ? i_a_data : i_b_data;
    wire [N*DWIDTH-1:0] lane_bus;
    logic [AWIDTH-1:0] addr;
    logic rd;
    logic [LEFT_W-1:0] reads_left;
    logic [LAT_W-1:0] lat_cnt;
    logic data_valid;

    ////////////////////
    // Address generator
    ////////////////////
    always_ff @(posedge clk) begin
      if (i_clear) begin
        rd <= 1'b0;
        reads_left <= '0;
        addr <= '0;
      end else if (i_fetch_go) begin
        rd <= 1'b1;
        reads_left <= LEFT_W'(N - 1);
        addr <= base;
      end else if (reads_left != '0) begin
        reads_left <= reads_left - 1'b1;
        addr <= addr + AWIDTH'(stride);
      end else begin
        rd <= 1'b0;
      end
    end

    // Counts from the first strobe, the returning words are valid for N cycles
    always_ff @(posedge clk) begin
      if (i_clear) begin
        lat_cnt <= '0;
      end else if ((rd || lat_cnt != '0) && lat_cnt != LAT_W'(LAT_END)) begin
        lat_cnt <= lat_cnt + 1'b1;
      end
    end

    assign data_valid = (lat_cnt >= LAT_W'(matmul_pkg::MEM_LATENCY)) &&
                        (lat_cnt < LAT_W'(LAT_END));

    ////////////////////
    // Lane skew, lane i is late by i cycles
    ////////////////////
    for (genvar i = 0; i < N; i++) begin : g_lane
      wire [DWIDTH-1:0] word = data_valid ? rdata[i*DWIDTH +: DWIDTH] : '0;

      if (i == 0) begin : g_direct
        assign lane_bus[DWIDTH-1:0] = word;
      end else begin : g_delay
        logic [DWIDTH-1:0] dly [i];

        always_ff @(posedge clk) begin
          if (i_clear) begin
            for (int d = 0; d < i; d++) begin
              dly[d] <= '0;
            end
          end else begin
            dly[0] <= word;
            for (int d = 1; d < i; d++) begin
              dly[d] <= dly[d-1];
            end
          end
        end

        assign lane_bus[i*DWIDTH +: DWIDTH] = dly[i-1];
      end
    end
  end

  assign o_a_addr = g_side[0].addr;
  assign o_a_rd   = g_side[0].rd;
  assign o_a_lane = g_side[0].lane_bus;
  assign o_b_addr = g_side[1].addr;
  assign o_b_rd   = g_side[1].rd;
  assign o_b_lane = g_side[1].lane_bus;

endmodule

// File: processing_element.sv
`timescale 1ns/100ps

module processing_element #(
  parameter int DWIDTH = 8
) (
  input  logic              clk,
  input  logic              i_clear,
  input  logic [DWIDTH-1:0] i_a,
  input  logic [DWIDTH-1:0] i_b,
  output logic [DWIDTH-1:0] o_a,
  output logic [DWIDTH-1:0] o_b,
  output logic [DWIDTH-1:0] o_acc
);

  // Operand flops ahead of the product flop and the accumulator
  localparam int OP_STAGES = matmul_pkg::MAC_STAGES - 2;
  localparam logic [DWIDTH-1:0] SAT_MAX = {1'b0, {(DWIDTH-1){1'b1}}};
  localparam logic [DWIDTH-1:0] SAT_MIN = {1'b1, {(DWIDTH-1){1'b0}}};

  logic signed [DWIDTH-1:0] a_pipe [OP_STAGES];
  logic signed [DWIDTH-1:0] b_pipe [OP_STAGES];
  logic signed [2*DWIDTH-1:0] prod_q;
  logic [DWIDTH:0] prod_top;
  logic [DWIDTH-1:0] prod_sat;

  // Neighbour links, one cycle per element
  always_ff @(posedge clk) begin
    if (i_clear) begin
      o_a <= '0;
      o_b <= '0;
    end else begin
      o_a <= i_a;
      o_b <= i_b;
    end
  end

  // The top DWIDTH+1 bits agree when the product fits in DWIDTH bits
  assign prod_top = prod_q[2*DWIDTH-1:DWIDTH-1];

  always_comb begin
    if (&prod_top || ~|prod_top) begin
      prod_sat = prod_q[DWIDTH-1:0];
    end else if (prod_q[2*DWIDTH-1]) begin
      prod_sat = SAT_MIN;
    end else begin
      prod_sat = SAT_MAX;
    end
  end

  ////////////////////
  // Multiply and accumulate
  ////////////////////
  always_ff @(posedge clk) begin
    if (i_clear) begin
      for (int s = 0; s < OP_STAGES; s++) begin
        a_pipe[s] <= '0;
        b_pipe[s] <= '0;
      end
      prod_q <= '0;
      o_acc <= '0;
    end else begin
      a_pipe[0] <= i_a;
      b_pipe[0] <= i_b;
      for (int s = 1; s < OP_STAGES; s++) begin
        a_pipe[s] <= a_pipe[s-1];
        b_pipe[s] <= b_pipe[s-1];
      end
      prod_q <= a_pipe[OP_STAGES-1] * b_pipe[OP_STAGES-1];
      // Accumulator wraps at DWIDTH bits
      o_acc <= o_acc + prod_sat;
    end
  end

endmodule

// File: result_drain.sv
`timescale 1ns/100ps

module result_drain #(
  parameter int N = 4,
  parameter int DWIDTH = 8,
  parameter int AWIDTH = 10,
  parameter int STRIDE_WIDTH = 8
) (
  input  logic                    clk,
  input  logic                    i_clear,
  input  logic                    i_drain_go,
  input  logic [AWIDTH-1:0]       i_base_c,
  input  logic [STRIDE_WIDTH-1:0] i_stride_c,
  input  logic [N*N*DWIDTH-1:0]   i_acc,
  output logic [AWIDTH-1:0]       o_c_addr,
  output logic [N*DWIDTH-1:0]     o_c_data,
  output logic                    o_c_valid,
  output logic                    o_drain_last
);

  localparam int COL_W = $clog2(N);

  // Column of C on the output port
  logic [COL_W-1:0] col;

  always_ff @(posedge clk) begin
    if (i_clear) begin
      o_c_valid <= 1'b0;
      col <= '0;
      o_c_addr <= '0;
    end else if (i_drain_go) begin
      o_c_valid <= 1'b1;
      col <= '0;
      o_c_addr <= i_base_c;
    end else if (o_c_valid) begin
      if (o_drain_last) begin
        o_c_valid <= 1'b0;
      end else begin
        col <= col + 1'b1;
        o_c_addr <= o_c_addr + AWIDTH'(i_stride_c);
      end
    end
  end

  assign o_drain_last = o_c_valid && (col == COL_W'(N - 1));

  // Lane i carries C[i][col], the accumulators hold still during the drain
  for (genvar i = 0; i < N; i++) begin : g_lane
    assign o_c_data[i*DWIDTH +: DWIDTH] = i_acc[(i*N + col)*DWIDTH +: DWIDTH];
  end

endmodule

// File: run_sequencer.sv
`timescale 1ns/100ps

module run_sequencer #(
  parameter int N = 4
) (
  input  logic clk,
  input  logic reset,
  input  logic i_start,
  input  logic i_drain_last,
  output logic o_clear,
  output logic o_fetch_go,
  output logic o_drain_go,
  output logic o_done
);

  // Fetch pulse to drain pulse: N reads, memory latency, lane skew,
  // propagation across the grid and the MAC pipeline
  localparam int WAIT_CYCLES = N + matmul_pkg::MEM_LATENCY + (N - 1) + 2 * (N - 1) +
                               matmul_pkg::MAC_STAGES;
  localparam int CNT_W = $clog2(WAIT_CYCLES + 1);

  matmul_pkg::seq_state_e state;
  logic [CNT_W-1:0] cycle_cnt;

  // A low start level aborts the run and clears every block
  assign o_clear = reset || !i_start;

  assign o_fetch_go = (state == matmul_pkg::ST_IDLE) && i_start;
  assign o_drain_go = (state == matmul_pkg::ST_WAIT) && (cycle_cnt == CNT_W'(WAIT_CYCLES));

  // cycle_cnt holds the number of cycles since the fetch pulse
  always_ff @(posedge clk) begin
    if (o_clear) begin
      state <= matmul_pkg::ST_IDLE;
      cycle_cnt <= '0;
      o_done <= 1'b0;
    end else begin
      o_done <= 1'b0;
      case (state)
        matmul_pkg::ST_IDLE: begin
          state <= matmul_pkg::ST_FETCH;
          cycle_cnt <= CNT_W'(1);
        end
        matmul_pkg::ST_FETCH: begin
          cycle_cnt <= cycle_cnt + 1'b1;
          if (cycle_cnt == CNT_W'(N)) begin
            state <= matmul_pkg::ST_WAIT;
          end
        end
        matmul_pkg::ST_WAIT: begin
          if (o_drain_go) begin
            state <= matmul_pkg::ST_DRAIN;
          end else begin
            cycle_cnt <= cycle_cnt + 1'b1;
          end
        end
        matmul_pkg::ST_DRAIN: begin
          if (i_drain_last) begin
            state <= matmul_pkg::ST_DONE;
            o_done <= 1'b1;
          end
        end
        // Parked here until start drops
        matmul_pkg::ST_DONE: state <= matmul_pkg::ST_DONE;
        default: state <= matmul_pkg::ST_IDLE;
      endcase
    end
  end

endmodule

// File: run_sim.sh
#!/bin/sh
# Builds the matrix multiplier testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sim.f --top-module tb_matmul -o tb_matmul
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_matmul)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx '>>> PASS'; then
  exit 0
fi
exit 1

// File: sim.f
matmul_pkg.sv
processing_element.sv
systolic_array.sv
operand_fetch.sv
result_drain.sv
run_sequencer.sv
matmul_top.sv
tb_matmul.sv

// File: systolic_array.sv
`timescale 1ns/100ps

module systolic_array #(
  parameter int N = 4,
  parameter int DWIDTH = 8
) (
  input  logic                     clk,
  input  logic                     i_clear,
  input  logic [N*DWIDTH-1:0]      i_a_lane,
  input  logic [N*DWIDTH-1:0]      i_b_lane,
  output logic [N*N*DWIDTH-1:0]    o_acc
);

  // A moves right along a row, B moves down a column.
  // The extra link at the far edge carries operands out of the grid
  wire [DWIDTH-1:0] a_link [N][N+1];
  wire [DWIDTH-1:0] b_link [N+1][N];

  for (genvar k = 0; k < N; k++) begin : g_edge
    assign a_link[k][0] = i_a_lane[k*DWIDTH +: DWIDTH];
    assign b_link[0][k] = i_b_lane[k*DWIDTH +: DWIDTH];
  end

  ////////////////////
  // Processing element grid
  ////////////////////
  for (genvar i = 0; i < N; i++) begin : g_row
    for (genvar j = 0; j < N; j++) begin : g_col
      // Element (i, j) owns C[i][j] at flat index i*N + j
      processing_element #(
        .DWIDTH(DWIDTH)
      ) i_processing_element (
        .clk     (clk),
        .i_clear (i_clear),
        .i_a     (a_link[i][j]),
        .i_b     (b_link[i][j]),
        .o_a     (a_link[i][j+1]),
        .o_b     (b_link[i+1][j]),
        .o_acc   (o_acc[(i*N + j)*DWIDTH +: DWIDTH])
      );
    end
  end

endmodule

// File: tb_matmul.sv
`timescale 1ns/100ps

module tb_matmul;

  localparam int N = matmul_pkg::DEF_N;
  localparam int DWIDTH = matmul_pkg::DEF_DWIDTH;
  localparam int AWIDTH = matmul_pkg::DEF_AWIDTH;
  localparam int STRIDE_WIDTH = matmul_pkg::DEF_STRIDE_WIDTH;
  localparam int WORD_W = N * DWIDTH;
  localparam int SAT_MAX = 2 ** (DWIDTH - 1) - 1;
  localparam int SAT_MIN = -(2 ** (DWIDTH - 1));
  localparam int MODE_IDENTITY = 0;
  localparam int MODE_RANDOM = 1;
  localparam int MODE_EXTREME = 2;
  // Reset check, five full runs and the aborted run
  localparam int NUM_TESTS = 7;
  localparam int TIMEOUT_NS = NUM_TESTS * (8 * N + 20) * 100;

  logic clk;
  logic reset;
  logic i_start;
  logic o_done;
  logic [AWIDTH-1:0] i_base_a, i_base_b, i_base_c;
  logic [STRIDE_WIDTH-1:0] i_stride_a, i_stride_b, i_stride_c;
  logic [AWIDTH-1:0] o_a_addr, o_b_addr, o_c_addr;
  logic o_a_rd, o_b_rd, o_c_valid;
  logic [WORD_W-1:0] i_a_data, i_b_data, o_c_data;

  logic [WORD_W-1:0] mem_a [2**AWIDTH];
  logic [WORD_W-1:0] mem_b [2**AWIDTH];
  logic signed [DWIDTH-1:0] a_mat [N][N];
  logic signed [DWIDTH-1:0] b_mat [N][N];
  logic [31:0] rng;
  logic a_req, b_req, quiet;
  logic [AWIDTH-1:0] a_req_addr, b_req_addr;
  int reads_a, reads_b, c_count, done_count;

  matmul_top #(
    .N(N),
    .DWIDTH(DWIDTH),
    .AWIDTH(AWIDTH),
    .STRIDE_WIDTH(STRIDE_WIDTH)
  ) i_matmul_top (
    .clk(clk), .reset(reset), .i_start(i_start), .o_done(o_done),
    .i_base_a(i_base_a), .i_base_b(i_base_b), .i_base_c(i_base_c),
    .i_stride_a(i_stride_a), .i_stride_b(i_stride_b), .i_stride_c(i_stride_c),
    .o_a_addr(o_a_addr), .o_a_rd(o_a_rd), .i_a_data(i_a_data),
    .o_b_addr(o_b_addr), .o_b_rd(o_b_rd), .i_b_data(i_b_data),
    .o_c_addr(o_c_addr), .o_c_data(o_c_data), .o_c_valid(o_c_valid)
  );

  always #50 clk = ~clk;

  ////////////////////
  // Reference model
  ////////////////////
  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Each product saturates to the element range, the sum wraps
  function automatic logic [DWIDTH-1:0] ref_elem(input int i, input int j);
    logic [DWIDTH-1:0] acc;
    int p;
    acc = '0;
    for (int k = 0; k < N; k++) begin
      p = int'(a_mat[i][k]) * int'(b_mat[k][j]);
      if (p > SAT_MAX) begin
        p = SAT_MAX;
      end else if (p < SAT_MIN) begin
        p = SAT_MIN;
      end
      acc = acc + DWIDTH'(p);
    end
    return acc;
  endfunction

  function automatic logic [WORD_W-1:0] exp_column(input int j);
    logic [WORD_W-1:0] col;
    for (int i = 0; i < N; i++) begin
      col[i*DWIDTH +: DWIDTH] = ref_elem(i, j);
    end
    return col;
  endfunction

  ////////////////////
  // Checks
  ////////////////////
  task automatic report_fail(input string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      report_fail($sformatf("error: %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_addr(input string name, input logic [AWIDTH-1:0] got,
                            input logic [AWIDTH-1:0] exp);
    if (got !== exp) begin
      report_fail($sformatf("error: %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_word(input string name, input logic [WORD_W-1:0] got,
                            input logic [WORD_W-1:0] exp);
    if (got !== exp) begin
      report_fail($sformatf("error: %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  // Memory models answer one cycle after the strobe
  always @(negedge clk) begin
    a_req = o_a_rd;
    b_req = o_b_rd;
    a_req_addr = o_a_addr;
    b_req_addr = o_b_addr;
    @(posedge clk);
    #10;
    if (a_req) begin
      i_a_data = mem_a[a_req_addr];
    end
    if (b_req) begin
      i_b_data = mem_b[b_req_addr];
    end
  end

  // Compare process for read addresses, result columns and done
  always @(negedge clk) begin
    if (!reset) begin
      if (o_a_rd) begin
        if (reads_a >= N) report_fail("memory A was read more than N times in one run");
        check_addr("o_a_addr", o_a_addr, i_base_a + AWIDTH'(reads_a) * AWIDTH'(i_stride_a));
        reads_a++;
      end
      if (o_b_rd) begin
        if (reads_b >= N) report_fail("memory B was read more than N times in one run");
        check_addr("o_b_addr", o_b_addr, i_base_b + AWIDTH'(reads_b) * AWIDTH'(i_stride_b));
        reads_b++;
      end
      if (quiet && (o_c_valid || o_done)) begin
        report_fail("a result or done pulse appeared after start was dropped");
      end
      if (o_c_valid && !quiet) begin
        if (c_count >= N) report_fail("more than N result cycles in one run");
        check_addr("o_c_addr", o_c_addr, i_base_c + AWIDTH'(c_count) * AWIDTH'(i_stride_c));
        check_word("o_c_data", o_c_data, exp_column(c_count));
        c_count++;
      end
      if (o_done && !quiet) begin
        if (c_count != N) report_fail("done pulsed before all N result columns");
        done_count++;
      end
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////
  task automatic fill_matrices(input int mode);
    for (int i = 0; i < N; i++) begin
      for (int k = 0; k < N; k++) begin
        rng = xorshift(rng);
        b_mat[i][k] = rng[DWIDTH-1:0];
        case (mode)
          MODE_IDENTITY: a_mat[i][k] = (i == k) ? DWIDTH'(1) : '0;
          MODE_RANDOM: begin
            rng = xorshift(rng);
            a_mat[i][k] = rng[DWIDTH-1:0];
          end
          // Products saturate both ways and the column sums wrap
          default: begin
            a_mat[i][k] = (i == k) ? DWIDTH'(SAT_MAX) : DWIDTH'(SAT_MIN);
            b_mat[i][k] = DWIDTH'(SAT_MIN);
          end
        endcase
      end
    end
  endtask

  // Loads the operands at their strided addresses and drives the bases
  task automatic set_config(input logic [AWIDTH-1:0] ba, input logic [STRIDE_WIDTH-1:0] sa,
                            input logic [AWIDTH-1:0] bb, input logic [STRIDE_WIDTH-1:0] sb,
                            input logic [AWIDTH-1:0] bc, input logic [STRIDE_WIDTH-1:0] sc);
    logic [WORD_W-1:0] col_word;
    logic [WORD_W-1:0] row_word;
    for (int k = 0; k < N; k++) begin
      for (int i = 0; i < N; i++) begin
        col_word[i*DWIDTH +: DWIDTH] = a_mat[i][k];
        row_word[i*DWIDTH +: DWIDTH] = b_mat[k][i];
      end
      mem_a[ba + AWIDTH'(k) * AWIDTH'(sa)] = col_word;
      mem_b[bb + AWIDTH'(k) * AWIDTH'(sb)] = row_word;
    end
    i_base_a = ba;
    i_stride_a = sa;
    i_base_b = bb;
    i_stride_b = sb;
    i_base_c = bc;
    i_stride_c = sc;
    reads_a = 0;
    reads_b = 0;
    c_count = 0;
    done_count = 0;
  endtask

  task automatic run_matmul(input logic [AWIDTH-1:0] ba, input logic [STRIDE_WIDTH-1:0] sa,
                            input logic [AWIDTH-1:0] bb, input logic [STRIDE_WIDTH-1:0] sb,
                            input logic [AWIDTH-1:0] bc, input logic [STRIDE_WIDTH-1:0] sc);
    @(posedge clk);
    #10;
    set_config(ba, sa, bb, sb, bc, sc);
    i_start = 1'b1;
    do begin
      @(negedge clk);
    end while (!o_done);
    // Start stays high a little longer so a repeated done would be seen
    repeat (2) @(posedge clk);
    #10;
    i_start = 1'b0;
    if (reads_a != N || reads_b != N) report_fail("a run did not issue exactly N reads");
    if (done_count != 1) report_fail("a run did not give exactly one done pulse");
  endtask

  task automatic abort_run();
    @(posedge clk);
    #10;
    set_config(10'h000, 8'd1, 10'h100, 8'd1, 10'h000, 8'd1);
    i_start = 1'b1;
    do begin
      @(negedge clk);
    end while (!o_a_rd);
    repeat (2 * N) @(posedge clk);
    #10;
    i_start = 1'b0;
    quiet = 1'b1;
    // Well past the point where the drain would have started
    repeat (4 * N + 10) @(posedge clk);
    #10;
    quiet = 1'b0;
  endtask

  initial begin
    #(TIMEOUT_NS);
    report_fail($sformatf("timeout: the tests did not finish within %0d ns", TIMEOUT_NS));
  end

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    i_start = 1'b0;
    i_base_a = '0;
    i_base_b = '0;
    i_base_c = '0;
    i_stride_a = '0;
    i_stride_b = '0;
    i_stride_c = '0;
    i_a_data = '0;
    i_b_data = '0;
    rng = 32'd48142;
    quiet = 1'b0;
    reads_a = 0;
    reads_b = 0;
    c_count = 0;
    done_count = 0;
    // Background words carry their own address, so a stray read is visible
    for (int ad = 0; ad < 2 ** AWIDTH; ad++) begin
      mem_a[ad] = WORD_W'({N{AWIDTH'(ad)}});
      mem_b[ad] = ~mem_a[ad];
    end
    repeat (2) @(posedge clk);
    #10;
    reset = 1'b0;
    @(negedge clk);
    check_bit("o_done", o_done, 1'b0);
    check_bit("o_c_valid", o_c_valid, 1'b0);
    check_bit("o_a_rd", o_a_rd, 1'b0);
    check_bit("o_b_rd", o_b_rd, 1'b0);

    fill_matrices(MODE_IDENTITY);
    run_matmul(10'h000, 8'd1, 10'h100, 8'd1, 10'h000, 8'd1);
    fill_matrices(MODE_RANDOM);
    run_matmul(10'h000, 8'd1, 10'h100, 8'd1, 10'h000, 8'd1);
    fill_matrices(MODE_EXTREME);
    run_matmul(10'h040, 8'd1, 10'h080, 8'd1, 10'h010, 8'd1);
    // Strides that wrap the A address around the top of memory
    fill_matrices(MODE_RANDOM);
    run_matmul(10'h3f0, 8'd7, 10'h123, 8'h55, 10'h2a0, 8'd3);
    fill_matrices(MODE_RANDOM);
    abort_run();
    fill_matrices(MODE_RANDOM);
    run_matmul(10'h200, 8'd2, 10'h300, 8'd4, 10'h050, 8'd5);

    $display(">>> PASS");
    $finish;
  end

endmodule
